/* design/ckeTimerPkg.sv */
// tick timer shared width, register address enum, response state enum and channel structs
package ckeTimerPkg;

	// ------------------------------
	// widths
	// ------------------------------

	// divider, count and compare all share this width
	parameter int divWidth = 16;

	// ------------------------------
	// register map
	// ------------------------------

	// host visible registers, 2-bit address
	typedef enum logic [1:0] {
		CTRL    = 2'd0,
		DIV     = 2'd1,
		COUNT   = 2'd2,
		COMPARE = 2'd3
	} regAddr_e;

	// ------------------------------
	// request / response channel
	// ------------------------------

	// 19 bits: write flag, address, write data
	typedef struct packed {
		logic                wr;
		regAddr_e            addr;
		logic [divWidth-1:0] wData;
	} regReq_t;

	// 17 bits: read data, error flag
	// err only on a write to the read-only COUNT
	typedef struct packed {
		logic [divWidth-1:0] rData;
		logic                err;
	} regRsp_t;

	// response sequencing in timerRegs
	typedef enum logic {
		IDLE    = 1'b0,
		RESPOND = 1'b1
	} rspState_e;

endpackage

/* design/ckeGenerator.sv */
// clock-enable pulse generator, register divisor or fixed divisor chosen by parameter
`timescale 1ns/1ns

module ckeGenerator #(
	// set for register mode, cleared for fixed mode
	parameter bit divReg   = 1'b1,
	parameter int divWidth = ckeTimerPkg::divWidth,
	// period in cycles, fixed mode only
	parameter int fixedDiv = 10
) (
	input  logic                iSysClk,
	input  logic                rstN,
	// divisor, register mode only; 0 keeps cke high
	input  logic [divWidth-1:0] div,
	input  logic                enable,
	output logic                cke
);

	generate
		if (divReg)
		begin : gRegMode
			// ------------------------------
			// register driven period
			// ------------------------------
			logic [divWidth-1:0] regCnt;
			logic                ckeReg;

			// one pulse every div+1 cycles, registered
			// >= so a divisor lowered mid-period restarts at once
			always_ff @(posedge iSysClk)
			begin
				if (!rstN)
				begin
					regCnt <= '0;
					ckeReg <= 1'b0;
				end
				else if (!enable)
				begin
					regCnt <= '0;
					ckeReg <= 1'b0;
				end
				else if (regCnt >= div)
				begin
					regCnt <= '0;
					ckeReg <= 1'b1;
				end
				else
				begin
					regCnt <= regCnt + 1'b1;
					ckeReg <= 1'b0;
				end
			end

			assign cke = ckeReg;

			// no pulse in the cycle after enable was low
			ckeNeedsEnable: assert property (@(posedge iSysClk) disable iff (!rstN)
				!$past(enable) |-> !cke);
		end
		else
		begin : gFixedMode
			// ------------------------------
			// parameter fixed period
			// ------------------------------
			localparam int cntW = (fixedDiv > 1) ? $clog2(fixedDiv) : 1;
			localparam logic [cntW-1:0] lastCnt = cntW'(fixedDiv - 1);

			logic [cntW-1:0] fixCnt;
			logic            endOfPeriod;

			// last count of the period
			assign endOfPeriod = (fixCnt == lastCnt);

			// free running 0 .. fixedDiv-1, held at 0 while disabled
			always_ff @(posedge iSysClk)
			begin
				if (!rstN)
					fixCnt <= '0;
				else if (!enable || endOfPeriod)
					fixCnt <= '0;
				else
					fixCnt <= fixCnt + 1'b1;
			end

			// pulse straight off the counter compare
			assign cke = enable && endOfPeriod;
		end
	endgenerate

endmodule

/* design/timerRegs.sv */
// timer register file with valid/ready request handling and response channel
`timescale 1ns/1ns

module timerRegs #(
	parameter int divWidth = ckeTimerPkg::divWidth
) (
	input  logic                  iSysClk,
	input  logic                  rstN,
	// request channel
	input  logic                  reqValid,
	output logic                  reqReady,
	input  ckeTimerPkg::regReq_t  req,
	// response channel
	output logic                  rspValid,
	input  logic                  rspReady,
	output ckeTimerPkg::regRsp_t  rsp,
	// timer control
	output logic                  enable,
	output logic [divWidth-1:0]   div,
	output logic [divWidth-1:0]   compare,
	output logic                  clear,
	input  logic [divWidth-1:0]   count
);

	localparam int dataW = ckeTimerPkg::divWidth;

	ckeTimerPkg::rspState_e state;
	logic                   accept;
	logic [dataW-1:0]       readData;

	// ------------------------------
	// handshake
	// ------------------------------

	// one request in flight, ready only while idle
	assign reqReady = (state == ckeTimerPkg::IDLE);
	assign rspValid = (state == ckeTimerPkg::RESPOND);
	assign accept   = reqValid && reqReady;

	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
			state <= ckeTimerPkg::IDLE;
		else if (accept)
			state <= ckeTimerPkg::RESPOND;
		else if (rspValid && rspReady)
			state <= ckeTimerPkg::IDLE;
	end

	// ------------------------------
	// register writes
	// ------------------------------

	// clear bit is a one-cycle pulse, never stored
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			enable  <= 1'b0;
			div     <= '0;
			compare <= '0;
			clear   <= 1'b0;
		end
		else
		begin
			clear <= 1'b0;
			if (accept && req.wr)
			begin
				case (req.addr)
					ckeTimerPkg::CTRL:
					begin
						enable <= req.wData[0];
						clear  <= req.wData[1];
					end
					ckeTimerPkg::DIV:     div     <= req.wData[divWidth-1:0];
					ckeTimerPkg::COMPARE: compare <= req.wData[divWidth-1:0];
					// COUNT read-only, flagged in the response
					default:              ;
				endcase
			end
		end
	end

	// ------------------------------
	// read mux and response
	// ------------------------------

	// ctrl bit 1 always reads back 0
	always_comb
	begin
		case (req.addr)
			ckeTimerPkg::CTRL:    readData = dataW'(enable);
			ckeTimerPkg::DIV:     readData = dataW'(div);
			ckeTimerPkg::COUNT:   readData = dataW'(count);
			ckeTimerPkg::COMPARE: readData = dataW'(compare);
			default:              readData = '0;
		endcase
	end

	// sampled at accept, held until taken
	// writes return zero data
	always_ff @(posedge iSysClk)
	begin
		if (accept)
		begin
			rsp.rData <= req.wr ? '0 : readData;
			rsp.err   <= req.wr && (req.addr == ckeTimerPkg::COUNT);
		end
	end

	// response frozen under back-pressure
	rspHoldsStable: assert property (@(posedge iSysClk) disable iff (!rstN)
		rspValid && !rspReady |=> $stable(rsp));

	// never accepting while a response is pending
	oneInFlight: assert property (@(posedge iSysClk) disable iff (!rstN)
		!(reqReady && rspValid));

endmodule

/* design/tickCounter.sv */
// tick pulse counter with sticky compare-match flag
`timescale 1ns/1ns

module tickCounter #(
	parameter int divWidth = ckeTimerPkg::divWidth
) (
	input  logic                iSysClk,
	input  logic                rstN,
	// one-cycle pulses from the register-mode generator
	input  logic                tick,
	// zeroes count and match, wins over tick
	input  logic                clear,
	input  logic [divWidth-1:0] compare,
	output logic [divWidth-1:0] count,
	output logic                match
);

	logic [divWidth-1:0] countNext;

	// wraps at full width
	assign countNext = count + 1'b1;

	// ------------------------------
	// count and match
	// ------------------------------

	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			count <= '0;
			match <= 1'b0;
		end
		else if (clear)
		begin
			count <= '0;
			match <= 1'b0;
		end
		else if (tick)
		begin
			count <= countNext;
			// sticky until the next clear
			if (countNext == compare)
				match <= 1'b1;
		end
	end

endmodule

/* design/ckeTimerTop.sv */
// tick timer top level, register file, tick and heartbeat generators, tick counter
`timescale 1ns/1ns

module ckeTimerTop #(
	parameter int divWidth     = ckeTimerPkg::divWidth,
	// heartbeat period in system clock cycles
	parameter int heartbeatDiv = 10
) (
	input  logic                 iSysClk,
	input  logic                 rstN,
	// request channel
	input  logic                 reqValid,
	output logic                 reqReady,
	input  ckeTimerPkg::regReq_t req,
	// response channel
	output logic                 rspValid,
	input  logic                 rspReady,
	output ckeTimerPkg::regRsp_t rsp,
	// timer outputs
	output logic                 tick,
	output logic                 heartbeat,
	output logic                 match
);

	logic                enable;
	logic                clear;
	logic [divWidth-1:0] div;
	logic [divWidth-1:0] compare;
	logic [divWidth-1:0] count;

	// ------------------------------
	// host registers
	// ------------------------------
	timerRegs #(
		.divWidth (divWidth)
	) u_timerRegs (
		.iSysClk  (iSysClk),
		.rstN     (rstN),
		.reqValid (reqValid),
		.reqReady (reqReady),
		.req      (req),
		.rspValid (rspValid),
		.rspReady (rspReady),
		.rsp      (rsp),
		.enable   (enable),
		.div      (div),
		.compare  (compare),
		.clear    (clear),
		.count    (count)
	);

	// ------------------------------
	// generators and counter
	// ------------------------------

	// programmable tick, period div+1
	ckeGenerator #(
		.divReg   (1'b1),
		.divWidth (divWidth),
		.fixedDiv (heartbeatDiv)
	) u_tickGen (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.div     (div),
		.enable  (enable),
		.cke     (tick)
	);

	// heartbeat runs regardless of register settings
	ckeGenerator #(
		.divReg   (1'b0),
		.divWidth (divWidth),
		.fixedDiv (heartbeatDiv)
	) u_heartbeatGen (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.div     ('0),
		.enable  (1'b1),
		.cke     (heartbeat)
	);

	tickCounter #(
		.divWidth (divWidth)
	) u_tickCounter (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.tick    (tick),
		.clear   (clear),
		.compare (compare),
		.count   (count),
		.match   (match)
	);

endmodule

/* tests/ckeTimerTb.sv */
// tick timer testbench with clock, reset, bus tasks, check task, watchdog and directed tests
`timescale 1ns/1ns

module ckeTimerTb;

	localparam int heartbeatDiv = 10;
	// reset, idle, tick period, stop, match, heartbeat, back-pressure, then margin
	localparam int timeoutCycles = 10 + 100 + 1200 + 200 + 300 + 100 + 300 + 800;

	logic                 iSysClk;
	logic                 rstN;
	logic                 reqValid;
	logic                 reqReady;
	ckeTimerPkg::regReq_t req;
	logic                 rspValid;
	logic                 rspReady;
	ckeTimerPkg::regRsp_t rsp;
	logic                 tick;
	logic                 heartbeat;
	logic                 match;

	integer seed;
	// tick pulses seen since the last clear
	int     tickSeen;
	// heartbeat spacing tracker
	int     hbGap;
	bit     hbArmed;
	int     hbCount;
	// match watch, expected set once tickSeen reaches matchAt
	bit     matchWatch;
	int     matchAt;

	ckeTimerTop #(
		.divWidth     (ckeTimerPkg::divWidth),
		.heartbeatDiv (heartbeatDiv)
	) u_ckeTimerTop (
		.iSysClk   (iSysClk),
		.rstN      (rstN),
		.reqValid  (reqValid),
		.reqReady  (reqReady),
		.req       (req),
		.rspValid  (rspValid),
		.rspReady  (rspReady),
		.rsp       (rsp),
		.tick      (tick),
		.heartbeat (heartbeat),
		.match     (match)
	);

	// 40 ns period
	always #20 iSysClk = ~iSysClk;

	// ------------------------------
	// checking and sampling
	// ------------------------------

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	endtask

	// outputs settle by the falling edge
	// every cycle passes through here exactly once
	task automatic sampleCycle();
		@(negedge iSysClk);
		hbGap++;
		if (heartbeat)
		begin
			if (hbArmed)
				checkEq("heartbeat", hbGap, heartbeatDiv);
			hbArmed = 1'b1;
			hbGap   = 0;
			hbCount++;
		end
		// counter lags the tick by one edge
		if (matchWatch)
			checkEq("match", match, tickSeen >= matchAt);
		if (tick)
			tickSeen++;
	endtask

	task automatic idleCycles(input int n);
		repeat (n)
		begin
			@(posedge iSysClk);
			sampleCycle();
		end
	endtask

	// tick must stay low the whole time
	task automatic quietCycles(input int n);
		repeat (n)
		begin
			@(posedge iSysClk);
			sampleCycle();
			checkEq("tick", tick, 1'b0);
		end
	endtask

	task automatic waitTick();
		while (!tick)
		begin
			@(posedge iSysClk);
			sampleCycle();
		end
	endtask

	// ------------------------------
	// bus tasks
	// ------------------------------

	// full request/response exchange, rspReady held low for hold cycles
	task automatic xfer(input logic wr, input ckeTimerPkg::regAddr_e addr,
		input logic [ckeTimerPkg::divWidth-1:0] wData, input int hold,
		output ckeTimerPkg::regRsp_t got);
		ckeTimerPkg::regRsp_t first;
		@(posedge iSysClk);
		reqValid <= 1'b1;
		req      <= '{wr: wr, addr: addr, wData: wData};
		sampleCycle();
		while (!reqReady)
		begin
			@(posedge iSysClk);
			sampleCycle();
		end
		// accept edge
		@(posedge iSysClk);
		reqValid <= 1'b0;
		sampleCycle();
		checkEq("rspValid", rspValid, 1'b1);
		first = rsp;
		repeat (hold)
		begin
			@(posedge iSysClk);
			sampleCycle();
			checkEq("rsp", rsp, first);
			checkEq("reqReady", reqReady, 1'b0);
			checkEq("rspValid", rspValid, 1'b1);
		end
		@(posedge iSysClk);
		rspReady <= 1'b1;
		sampleCycle();
		got = rsp;
		checkEq("rsp", got, first);
		// response taken here
		@(posedge iSysClk);
		rspReady <= 1'b0;
		sampleCycle();
		checkEq("rspValid", rspValid, 1'b0);
		checkEq("reqReady", reqReady, 1'b1);
	endtask

	// only COUNT writes flag an error
	task automatic regWrite(input ckeTimerPkg::regAddr_e addr,
		input logic [ckeTimerPkg::divWidth-1:0] data);
		ckeTimerPkg::regRsp_t got;
		xfer(1'b1, addr, data, 0, got);
		checkEq("rsp.err", got.err, addr == ckeTimerPkg::COUNT);
	endtask

	task automatic regRead(input ckeTimerPkg::regAddr_e addr, input int hold,
		input logic [ckeTimerPkg::divWidth-1:0] exp);
		ckeTimerPkg::regRsp_t got;
		xfer(1'b0, addr, '0, hold, got);
		checkEq("rsp.rData", got.rData, exp);
		checkEq("rsp.err", got.err, 1'b0);
	endtask

	// stop ticks first so no pulse falls into the clear cycle
	task automatic clearCount();
		regWrite(ckeTimerPkg::CTRL, 16'h0000);
		regWrite(ckeTimerPkg::CTRL, 16'h0002);
		tickSeen = 0;
	endtask

	// ------------------------------
	// directed tests
	// ------------------------------

	task automatic resetTest();
		checkEq("tick", tick, 1'b0);
		checkEq("heartbeat", heartbeat, 1'b0);
		checkEq("match", match, 1'b0);
		checkEq("rspValid", rspValid, 1'b0);
		checkEq("reqReady", reqReady, 1'b1);
		regRead(ckeTimerPkg::CTRL, 0, 16'h0000);
		regRead(ckeTimerPkg::DIV, 0, 16'h0000);
		regRead(ckeTimerPkg::COUNT, 0, 16'h0000);
		regRead(ckeTimerPkg::COMPARE, 0, 16'h0000);
		// read-only, write ignored
		regWrite(ckeTimerPkg::COUNT, 16'h1234);
		regRead(ckeTimerPkg::COUNT, 0, 16'h0000);
	endtask

	task automatic tickPeriodTest();
		int d;
		int gap;
		for (int i = 0; i < 5; i++)
		begin
			d = 1 + ($unsigned($random(seed)) % 20);
			regWrite(ckeTimerPkg::DIV, d);
			regWrite(ckeTimerPkg::CTRL, 16'h0001);
			// align on a pulse, then measure spacing
			waitTick();
			repeat (3)
			begin
				gap = 0;
				do
				begin
					@(posedge iSysClk);
					sampleCycle();
					gap++;
				end while (!tick);
				checkEq("tick period", gap, d + 1);
			end
			regWrite(ckeTimerPkg::CTRL, 16'h0000);
		end
		// div 0, tick every cycle
		regWrite(ckeTimerPkg::DIV, 16'h0000);
		regWrite(ckeTimerPkg::CTRL, 16'h0001);
		waitTick();
		repeat (20)
		begin
			@(posedge iSysClk);
			sampleCycle();
			checkEq("tick", tick, 1'b1);
		end
		regWrite(ckeTimerPkg::CTRL, 16'h0000);
	endtask

	task automatic stopTest();
		clearCount();
		regWrite(ckeTimerPkg::DIV, 16'd3);
		regWrite(ckeTimerPkg::CTRL, 16'h0001);
		idleCycles(37);
		regWrite(ckeTimerPkg::CTRL, 16'h0000);
		quietCycles(10);
		regRead(ckeTimerPkg::COUNT, 0, tickSeen);
		quietCycles(15);
		regRead(ckeTimerPkg::COUNT, 0, tickSeen);
		checkEq("ticks observed", tickSeen > 0, 1'b1);
	endtask

	task automatic matchTest();
		clearCount();
		matchAt = 5;
		regWrite(ckeTimerPkg::COMPARE, 16'd5);
		regWrite(ckeTimerPkg::DIV, 16'd3);
		matchWatch = 1'b1;
		regWrite(ckeTimerPkg::CTRL, 16'h0001);
		// run past the compare value
		while (tickSeen < 8)
			idleCycles(1);
		checkEq("match", match, 1'b1);
		matchWatch = 1'b0;
		regWrite(ckeTimerPkg::CTRL, 16'h0002);
		checkEq("match", match, 1'b0);
		regRead(ckeTimerPkg::COUNT, 0, 16'h0000);
	endtask

	// spacing itself is checked on every sampled cycle
	task automatic heartbeatTest();
		regWrite(ckeTimerPkg::DIV, 1 + ($unsigned($random(seed)) % 20));
		regWrite(ckeTimerPkg::CTRL, 16'h0001);
		hbCount = 0;
		idleCycles(60);
		checkEq("heartbeat pulses", hbCount, 6);
		regWrite(ckeTimerPkg::CTRL, 16'h0000);
		hbCount = 0;
		idleCycles(40);
		checkEq("heartbeat pulses", hbCount, 4);
	endtask

	task automatic backPressureTest();
		logic [ckeTimerPkg::divWidth-1:0] v;
		int hold;
		repeat (4)
		begin
			v    = $random(seed);
			hold = 1 + ($unsigned($random(seed)) % 8);
			regWrite(ckeTimerPkg::COMPARE, v);
			regRead(ckeTimerPkg::COMPARE, hold, v);
			v    = $random(seed);
			hold = 1 + ($unsigned($random(seed)) % 8);
			regWrite(ckeTimerPkg::DIV, v);
			regRead(ckeTimerPkg::DIV, hold, v);
		end
	endtask

	// ------------------------------
	// main sequence and watchdog
	// ------------------------------

	initial
	begin
		iSysClk    = 1'b0;
		rstN       = 1'b0;
		reqValid   = 1'b0;
		rspReady   = 1'b0;
		req        = '0;
		seed       = 32'hb2ccc450;
		tickSeen   = 0;
		hbGap      = 0;
		hbArmed    = 1'b0;
		hbCount    = 0;
		matchWatch = 1'b0;
		matchAt    = 0;
		// reset low over two rising edges
		@(posedge iSysClk);
		sampleCycle();
		@(posedge iSysClk);
		rstN <= 1'b1;
		sampleCycle();
		resetTest();
		tickPeriodTest();
		stopTest();
		matchTest();
		heartbeatTest();
		backPressureTest();
		$display("ALL CHECKS PASSED");
		$finish;
	end

	initial
	begin
		repeat (timeoutCycles) @(posedge iSysClk);
		$display("timeout, the tests did not finish within %0d clock cycles", timeoutCycles);
		$display("CHECKS FAILED");
		$fatal(1);
	end

endmodule

/* ckeTimerTop.f */
design/ckeTimerPkg.sv
design/ckeGenerator.sv
design/timerRegs.sv
design/tickCounter.sv
design/ckeTimerTop.sv
tests/ckeTimerTb.sv

/* Bender.yml */
package:
  name: ckeTimer

sources:
  # package first, then leaf modules, then the top level
  - files:
      - design/ckeTimerPkg.sv
      - design/ckeGenerator.sv
      - design/timerRegs.sv
      - design/tickCounter.sv
      - design/ckeTimerTop.sv

  # testbench, simulation only
  - target: test
    files:
      - tests/ckeTimerTb.sv
